/* Bender.yml */
package:
  name: decode_stage

export_include_dirs:
  - verilog

sources:
  - verilog/decodePkg.sv
  - verilog/controlUnit.sv
  - verilog/regFileBypass.sv
  - verilog/decodeStage.sv
  - target: test
    files:
      - sim/decodeTb.sv

/* sim.f */
+incdir+verilog
verilog/decodePkg.sv
verilog/controlUnit.sv
verilog/regFileBypass.sv
verilog/decodeStage.sv
sim/decodeTb.sv

/* sim/decodeTb.sv */
// ************************************************************
// Table-driven testbench for the decode stage, one row per cycle
// Checks control, err, immediates and reads against a register model
// ************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module decodeTb;

   import decodePkg::*;

   // Single-bit control flags in struct order
   localparam logic [14:0] rw  = 15'd1 << 14;  // regWrite
   localparam logic [14:0] zx  = 15'd1 << 13;  // zeroExt
   localparam logic [14:0] i8  = 15'd1 << 12;  // immSrc
   localparam logic [14:0] me  = 15'd1 << 11;  // memEnable
   localparam logic [14:0] mw  = 15'd1 << 10;
   localparam logic [14:0] mr  = 15'd1 << 9;
   localparam logic [14:0] aj  = 15'd1 << 8;   // aluJump
   localparam logic [14:0] ia  = 15'd1 << 7;
   localparam logic [14:0] ib  = 15'd1 << 6;
   localparam logic [14:0] ci  = 15'd1 << 5;
   localparam logic [14:0] beq = 15'd1 << 4;
   localparam logic [14:0] bne = 15'd1 << 3;
   localparam logic [14:0] blt = 15'd1 << 2;
   localparam logic [14:0] bge = 15'd1 << 1;
   localparam logic [14:0] hlt = 15'd1;
   localparam logic [15:0] nopInstr  = 16'h0800;
   localparam logic [15:0] fixedData = 16'h5A5A;  // Rows without LFSR data

   logic                   clk;
   logic                   reset;
   logic [15:0]            instruction;
   logic [`DATA_WIDTH-1:0] writeData;
   ctrlSignalsT            ctrl;
   logic                   err;
   logic [`DATA_WIDTH-1:0] readData1;
   logic [`DATA_WIDTH-1:0] readData2;
   logic [`DATA_WIDTH-1:0] imm5Ext;
   logic [`DATA_WIDTH-1:0] imm8Ext;
   logic [`DATA_WIDTH-1:0] imm11Ext;

   logic [15:0]            instrQ [$];
   bit                     lfsrQ [$];
   bit                     errQ [$];
   bit                     rstQ [$];   // Row holds reset high
   ctrlSignalsT            ctrlQ [$];
   string                  nameQ [$];

   logic [`DATA_WIDTH-1:0] model [`REG_COUNT];  // Reference registers
   logic [31:0]            lfsrState;
   string                  curName;
   int                     rowErrors;
   int                     passCount;
   int                     failCount;

   decodeStage DUT (.*);

   always #5 clk = ~clk;  // 10 ns period

   function automatic logic [31:0] lfsrStep(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // Galois taps 32,22,2,1
   endfunction

   // One LFSR step per data bit taken
   function automatic logic [15:0] nextWord();
      logic [15:0] w;
      w = '0;
      for (int k = 0; k < 16; k++) begin
         w         = {w[14:0], lfsrState[0]};
         lfsrState = lfsrStep(lfsrState);
      end
      return w;
   endfunction

   function automatic logic [2:0] destOf(regDstT d, logic [15:0] ins);
      case (d)
         dstBits7to5:  return ins[7:5];
         dstBits10to8: return ins[10:8];
         dstBits4to2:  return ins[4:2];
         default:      return 3'd7;  // Link register
      endcase
   endfunction

   task automatic addRow(logic [15:0] ins, bit useLfsr, bit expErr, logic [14:0] flags,
                         regDstT dst, wbSelT wb, srcSelT s1, srcSelT s2, aluOpT op,
                         string name);
      ctrlSignalsT e;
      e = {flags, dst, wb, s1, s2, op};
      instrQ.push_back(ins);
      lfsrQ.push_back(useLfsr);
      errQ.push_back(expErr);
      rstQ.push_back(1'b0);
      ctrlQ.push_back(e);
      nameQ.push_back(name);
   endtask

   task automatic checkValue(string what, logic [31:0] got, logic [31:0] exp);
      assert (got === exp) else begin
         $display("FAIL %0t ns %s %s: got %h expected %h", $time, curName, what, got, exp);
         rowErrors++;
      end
   endtask

   initial begin
      logic [15:0] ins;
      ctrlSignalsT e;
      logic [2:0]  wSel;
      logic [15:0] exp1;
      logic [15:0] exp2;
      logic [15:0] exp5;
      logic [15:0] exp8;
      clk         = 1'b0;
      reset       = 1'b1;
      instruction = nopInstr;
      writeData   = '0;
      lfsrState   = 32'h5fe356d0;
      passCount   = 0;
      failCount   = 0;
      for (int r = 0; r < `REG_COUNT; r++)
         model[r] = '0;
      addRow(16'hC185, 1, 0, rw|zx|i8, dstBits10to8, wbAlu, srcReg, srcImm, aluPassB, "lbi r1");
      addRow(16'h4153, 1, 0, rw, dstBits7to5, wbAlu, srcReg, srcImm, aluAdd, "addi r2");
      addRow(16'h5276, 1, 0, rw|zx, dstBits7to5, wbAlu, srcReg, srcImm, aluXor, "xori r3");
      addRow(16'h5B9F, 1, 0, rw|zx|ib, dstBits7to5, wbAlu, srcReg, srcImm, aluAndn, "andni r4");
      addRow(16'h49A4, 1, 0, rw|ia|ci, dstBits7to5, wbAlu, srcReg, srcImm, aluSub, "subi r5");
      addRow(16'hD94C, 1, 0, rw, dstBits4to2, wbAlu, srcReg, srcReg, aluAdd, "add r3");
      addRow(16'hDB99, 1, 0, rw|ia|ci, dstBits4to2, wbAlu, srcReg, srcReg, aluSub, "sub r6");
      addRow(16'hDDC6, 1, 0, rw, dstBits4to2, wbAlu, srcReg, srcReg, aluXor, "xor r1");
      addRow(16'hDA63, 1, 0, rw|ib, dstBits4to2, wbAlu, srcReg, srcReg, aluAndn, "andn r0");
      addRow(16'hD15F, 1, 0, rw, dstBits4to2, wbAlu, srcReg, srcReg, aluSrl, "srl r7");
      addRow(16'hAEE3, 1, 0, rw, dstBits7to5, wbAlu, srcReg, srcImm, aluSll, "slli r7");
      addRow(16'hE150, 1, 0, rw|ib|ci, dstBits4to2, wbFlag, srcReg, srcReg, aluEq, "seq r4");
      addRow(16'hFB94, 1, 0, rw, dstBits4to2, wbFlag, srcReg, srcReg, aluCo, "sco r5");
      addRow(16'h8A61, 1, 0, rw|me|mr, dstBits7to5, wbMem, srcReg, srcImm, aluAdd, "ld r3");
      addRow(16'h839E, 1, 0, me|mw, dstBits7to5, wbAlu, srcReg, srcImm, aluAdd, "st");
      addRow(16'h9AA2, 1, 0, rw|me|mw, dstBits10to8, wbAlu, srcReg, srcImm, aluAdd, "stu r2");
      addRow(16'h64F6, 0, 0, i8|beq, dstBits7to5, wbAlu, srcReg, srcZero, aluAdd, "beqz");
      addRow(16'h6880, 0, 0, i8|bne, dstBits7to5, wbAlu, srcReg, srcZero, aluAdd, "bnez");
      addRow(16'h717F, 0, 0, i8|blt, dstBits7to5, wbAlu, srcReg, srcZero, aluAdd, "bltz");
      addRow(16'h7D25, 0, 0, i8|bge, dstBits7to5, wbAlu, srcReg, srcZero, aluAdd, "bgez");
      addRow(16'h3456, 1, 0, rw, dstReg7, wbRetAddr, srcPc, srcImm, aluAdd, "jal r7");
      addRow(16'h21E3, 0, 0, 0, dstReg7, wbRetAddr, srcPc, srcImm, aluAdd, "j");
      addRow(16'h3FF0, 1, 0, rw|i8|aj, dstReg7, wbRetAddr, srcReg, srcImm, aluAdd, "jalr r7");
      addRow(16'h2B0C, 0, 0, i8|aj, dstReg7, wbRetAddr, srcReg, srcImm, aluAdd, "jr");
      addRow(16'h953C, 1, 0, rw|zx|i8, dstBits10to8, wbAlu, srcReg, srcImm, aluSlbi, "slbi r5");
      addRow(16'h17FF, 1, 1, 0, dstBits7to5, wbAlu, srcReg, srcReg, aluAdd, "illegal");
      addRow(16'h0FC0, 1, 0, 0, dstBits7to5, wbAlu, srcReg, srcReg, aluAdd, "nop r7 r6");
      addRow(16'h03A0, 1, 0, hlt, dstBits7to5, wbAlu, srcReg, srcReg, aluAdd, "halt");
      addRow(nopInstr, 0, 0, 0, dstBits7to5, wbAlu, srcReg, srcReg, aluAdd, "reset");
      rstQ[rstQ.size()-1] = 1'b1;
      addRow(16'h0940, 1, 0, 0, dstBits7to5, wbAlu, srcReg, srcReg, aluAdd, "zero r1 r2");
      addRow(16'h0FA0, 1, 0, 0, dstBits7to5, wbAlu, srcReg, srcReg, aluAdd, "zero r7 r5");
      addRow(16'h0B80, 1, 0, 0, dstBits7to5, wbAlu, srcReg, srcReg, aluAdd, "zero r3 r4");
      addRow(16'h0E00, 1, 0, 0, dstBits7to5, wbAlu, srcReg, srcReg, aluAdd, "zero r6 r0");
      repeat (3) @(posedge clk);       // Reset for 3 cycles
      #1;
      for (int i = 0; i < nameQ.size(); i++) begin
         ins         = instrQ[i];
         e           = ctrlQ[i];
         curName     = nameQ[i];
         rowErrors   = 0;
         reset       = rstQ[i];
         instruction = ins;
         writeData   = lfsrQ[i] ? nextWord() : fixedData;
         #8;                           // Just before the next edge
         wSel = destOf(e.regDst, ins);
         exp1 = model[ins[10:8]];
         exp2 = model[ins[7:5]];
         if (e.regWrite && ins[10:8] == wSel)
            exp1 = writeData;          // Bypass
         if (e.regWrite && ins[7:5] == wSel)
            exp2 = writeData;
         exp5 = e.zeroExt ? {11'b0, ins[4:0]} : {{11{ins[4]}}, ins[4:0]};
         exp8 = e.zeroExt ? {8'b0, ins[7:0]} : {{8{ins[7]}}, ins[7:0]};
         checkValue("ctrl", ctrl, e);
         checkValue("err", err, errQ[i]);
         checkValue("readData1", readData1, exp1);
         checkValue("readData2", readData2, exp2);
         checkValue("imm5Ext", imm5Ext, exp5);
         checkValue("imm8Ext", imm8Ext, exp8);
         checkValue("imm11Ext", imm11Ext, {{5{ins[10]}}, ins[10:0]});
         if (rstQ[i]) begin
            for (int r = 0; r < `REG_COUNT; r++)
               model[r] = '0;
         end else if (e.regWrite) begin
            model[wSel] = writeData;
         end
         if (rowErrors == 0) begin
            passCount++;
            $display("row %0d %s: ok", i, curName);
         end else begin
            failCount++;
            $display("row %0d %s: %0d mismatches", i, curName, rowErrors);
         end
         @(posedge clk);
         #1;                           // Drive after the edge
      end
      $display("%0d rows passed, %0d rows failed", passCount, failCount);
      if (failCount == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // Watchdog sized from the table length
   initial begin
      #1;
      #((nameQ.size() + 10) * 10);
      $display("Timeout: the table did not finish in the expected time");
      $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/controlUnit.sv */
// ************************************************************
// Main decoder: opcode and func bits to the control struct
// Flags unknown and exception-return opcodes as illegal
// ************************************************************
`timescale 1ns/100ps
`default_nettype none

module controlUnit (
   input  decodePkg::opcodeT      opcode,
   input  logic [1:0]             func,   // Instruction bits 1..0
   output decodePkg::ctrlSignalsT ctrl,
   output logic                   err
);

   import decodePkg::*;

   always_comb begin
      ctrl = '0;        // Everything inactive by default
      err  = 1'b0;
      case (opcode)
         opHalt: ctrl.halt = 1'b1;
         opNop: ;       // Nothing to do
         opAddi, opSubi, opXori, opAndni,
         opRoli, opSlli, opRori, opSrli: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = dstBits7to5;  // I-format Rd
            ctrl.aluSrc2  = srcImm;       // imm5
            case (opcode)
               opSubi: begin
                  ctrl.aluOp   = aluSub;  // Imm - Rs
                  ctrl.invA    = 1'b1;
                  ctrl.carryIn = 1'b1;
               end
               opXori: begin
                  ctrl.aluOp   = aluXor;
                  ctrl.zeroExt = 1'b1;
               end
               opAndni: begin
                  ctrl.aluOp   = aluAndn;
                  ctrl.invB    = 1'b1;
                  ctrl.zeroExt = 1'b1;
               end
               opRoli:  ctrl.aluOp = aluRol;
               opSlli:  ctrl.aluOp = aluSll;
               opRori:  ctrl.aluOp = aluRor;
               opSrli:  ctrl.aluOp = aluSrl;
               default: ctrl.aluOp = aluAdd;  // addi
            endcase
         end
         opSt, opLd, opStu: begin
            ctrl.memEnable = 1'b1;
            ctrl.aluSrc2   = srcImm;          // Rs + imm5
            ctrl.memWrite  = (opcode != opLd);
            ctrl.memRead   = (opcode == opLd);
            ctrl.regWrite  = (opcode != opSt);
            ctrl.regDst    = (opcode == opStu) ? dstBits10to8 : dstBits7to5;
            ctrl.memToReg  = (opcode == opLd) ? wbMem : wbAlu;  // stu writes address
         end
         opLbi, opSlbi: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = dstBits10to8;
            ctrl.immSrc   = 1'b1;             // imm8
            ctrl.zeroExt  = 1'b1;
            ctrl.aluSrc2  = srcImm;
            ctrl.aluOp    = (opcode == opLbi) ? aluPassB : aluSlbi;
         end
         opBtr: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = dstBits4to2;
            ctrl.aluOp    = aluBtr;
         end
         opAluReg: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = dstBits4to2;      // R-format Rd
            case (func)
               2'b00: ctrl.aluOp = aluAdd;
               2'b01: begin
                  ctrl.aluOp   = aluSub;      // Rt - Rs
                  ctrl.invA    = 1'b1;
                  ctrl.carryIn = 1'b1;
               end
               2'b10: ctrl.aluOp = aluXor;
               default: begin
                  ctrl.aluOp = aluAndn;
                  ctrl.invB  = 1'b1;
               end
            endcase
         end
         opShReg: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = dstBits4to2;
            case (func)
               2'b00:   ctrl.aluOp = aluRol;
               2'b01:   ctrl.aluOp = aluSll;
               2'b10:   ctrl.aluOp = aluRor;
               default: ctrl.aluOp = aluSrl;
            endcase
         end
         opSeq, opSlt, opSle, opSco: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = dstBits4to2;
            ctrl.memToReg = wbFlag;           // Compare flag to Rd
            ctrl.invB     = (opcode != opSco); // Rs - Rt for compares
            ctrl.carryIn  = (opcode != opSco);
            case (opcode)
               opSeq:   ctrl.aluOp = aluEq;
               opSlt:   ctrl.aluOp = aluLt;
               opSle:   ctrl.aluOp = aluLe;
               default: ctrl.aluOp = aluCo;
            endcase
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            ctrl.immSrc   = 1'b1;             // imm8 offset
            ctrl.aluSrc2  = srcZero;          // Rs against zero
            ctrl.branchEq = (opcode == opBeqz);
            ctrl.branchNe = (opcode == opBnez);
            ctrl.branchLt = (opcode == opBltz);
            ctrl.branchGe = (opcode == opBgez);
         end
         opJ, opJal: begin
            ctrl.aluSrc1  = srcPc;            // PC + imm11
            ctrl.aluSrc2  = srcImm;
            ctrl.regWrite = (opcode == opJal);
            ctrl.regDst   = dstReg7;
            ctrl.memToReg = wbRetAddr;
         end
         opJr, opJalr: begin
            ctrl.aluJump  = 1'b1;             // Rs + imm8
            ctrl.immSrc   = 1'b1;
            ctrl.aluSrc2  = srcImm;
            ctrl.regWrite = (opcode == opJalr);
            ctrl.regDst   = dstReg7;
            ctrl.memToReg = wbRetAddr;
         end
         default: err = 1'b1;  // Illegal or siic/rti, no writes
      endcase
   end

endmodule

`default_nettype wire

/* verilog/decodePkg.sv */
// ************************************************************
// Decode types: opcodes, ALU ops, mux selects, control struct
// ************************************************************
`default_nettype none

package decodePkg;

   // Major opcodes, instruction bits 15..11
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opJ     = 5'b00100,
      opJr    = 5'b00101,
      opJal   = 5'b00110,
      opJalr  = 5'b00111,
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opBltz  = 5'b01110,
      opBgez  = 5'b01111,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opSlbi  = 5'b10010,
      opStu   = 5'b10011,
      opRoli  = 5'b10100,
      opSlli  = 5'b10101,
      opRori  = 5'b10110,
      opSrli  = 5'b10111,
      opLbi   = 5'b11000,
      opBtr   = 5'b11001,
      opShReg = 5'b11010, // Func picks rol/sll/ror/srl
      opAluReg = 5'b11011, // Func picks add/sub/xor/andn
      opSeq   = 5'b11100,
      opSlt   = 5'b11101,
      opSle   = 5'b11110,
      opSco   = 5'b11111
   } opcodeT;

   typedef enum logic [3:0] {
      aluAdd, aluSub, aluXor, aluAndn,
      aluRol, aluSll, aluRor, aluSrl,
      aluEq, aluLt, aluLe, aluCo,
      aluPassB, aluBtr, aluSlbi
   } aluOpT;

   typedef enum logic [1:0] {srcReg, srcImm, srcZero, srcPc} srcSelT;

   // Write register field, r7 for links
   typedef enum logic [1:0] {dstBits7to5, dstBits10to8, dstBits4to2, dstReg7} regDstT;

   typedef enum logic [1:0] {wbAlu, wbMem, wbRetAddr, wbFlag} wbSelT;

   typedef struct packed {
      logic   regWrite;
      logic   zeroExt;   // Zero extend imm5/imm8
      logic   immSrc;    // 1 = imm8, 0 = imm5
      logic   memEnable;
      logic   memWrite;
      logic   memRead;
      logic   aluJump;   // Target from ALU (jr/jalr)
      logic   invA;
      logic   invB;
      logic   carryIn;
      logic   branchEq;
      logic   branchNe;
      logic   branchLt;
      logic   branchGe;
      logic   halt;
      regDstT regDst;
      wbSelT  memToReg;
      srcSelT aluSrc1;
      srcSelT aluSrc2;
      aluOpT  aluOp;
   } ctrlSignalsT;

endpackage

`default_nettype wire

/* verilog/decodeStage.sv */
// ************************************************************
// Decode stage top: control, register file, immediate extend
// Outputs are combinational, register writes land on clk edge
// ************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module decodeStage (
   input  logic                   clk,
   input  logic                   reset,
   input  logic [15:0]            instruction,
   input  logic [`DATA_WIDTH-1:0] writeData,
   output decodePkg::ctrlSignalsT ctrl,
   output logic                   err,
   output logic [`DATA_WIDTH-1:0] readData1,
   output logic [`DATA_WIDTH-1:0] readData2,
   output logic [`DATA_WIDTH-1:0] imm5Ext,
   output logic [`DATA_WIDTH-1:0] imm8Ext,
   output logic [`DATA_WIDTH-1:0] imm11Ext
);

   import decodePkg::*;

   logic [`REG_SEL_WIDTH-1:0] writeSel;
   logic [4:0]                imm5;
   logic [7:0]                imm8;
   logic [10:0]               imm11;

   assign imm5  = instruction[4:0];
   assign imm8  = instruction[7:0];
   assign imm11 = instruction[10:0];

   controlUnit ctrlUnit (
      .opcode (opcodeT'(instruction[15:11])),
      .func   (instruction[1:0]),
      .ctrl   (ctrl),
      .err    (err)
   );

   // Zero or sign extend per control, imm11 always signed
   assign imm5Ext = ctrl.zeroExt ? {{(`DATA_WIDTH-5){1'b0}}, imm5}
                                 : {{(`DATA_WIDTH-5){imm5[4]}}, imm5};
   assign imm8Ext = ctrl.zeroExt ? {{(`DATA_WIDTH-8){1'b0}}, imm8}
                                 : {{(`DATA_WIDTH-8){imm8[7]}}, imm8};
   assign imm11Ext = {{(`DATA_WIDTH-11){imm11[10]}}, imm11};

   always_comb begin
      case (ctrl.regDst)
         dstBits7to5:  writeSel = instruction[7:5];   // I-format Rd
         dstBits10to8: writeSel = instruction[10:8];  // Rs, lbi/slbi/stu
         dstBits4to2:  writeSel = instruction[4:2];   // R-format Rd
         default:      writeSel = `REG_SEL_WIDTH'(7); // Link register
      endcase
   end

   // Illegal opcodes already have regWrite low
   regFileBypass regFile (
      .clk       (clk),
      .reset     (reset),
      .read1Sel  (instruction[10:8]),
      .read2Sel  (instruction[7:5]),
      .writeSel  (writeSel),
      .writeData (writeData),
      .writeEn   (ctrl.regWrite),
      .read1Data (readData1),
      .read2Data (readData2)
   );

endmodule

`default_nettype wire

/* verilog/decode_params.svh */
// ************************************************************
// Width and size macros shared by the decode stage RTL
// Include wherever a data or register-select width is needed
// ************************************************************

`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Data word, also the width of every extended immediate
`define DATA_WIDTH 16

// General purpose registers r0..r7
`define REG_COUNT 8

// Enough bits to name any register
`define REG_SEL_WIDTH 3

`endif

/* verilog/regFileBypass.sv */
// ************************************************************
// Register file, two async read ports, one sync write port
// Reads of the register being written return the new data
// ************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "decode_params.svh"

module regFileBypass (
   input  logic                      clk,
   input  logic                      reset,
   input  logic [`REG_SEL_WIDTH-1:0] read1Sel,
   input  logic [`REG_SEL_WIDTH-1:0] read2Sel,
   input  logic [`REG_SEL_WIDTH-1:0] writeSel,
   input  logic [`DATA_WIDTH-1:0]    writeData,
   input  logic                      writeEn,
   output logic [`DATA_WIDTH-1:0]    read1Data,
   output logic [`DATA_WIDTH-1:0]    read2Data
);

   logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];  // r0..r7
   logic                   hit1;
   logic                   hit2;

   always_ff @(posedge clk) begin
      if (reset) begin                 // Clear all, write blocked
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeSel] <= writeData;
      end
   end

   // Same-cycle bypass of the pending write
   assign hit1 = writeEn && (read1Sel == writeSel);
   assign hit2 = writeEn && (read2Sel == writeSel);

   assign read1Data = hit1 ? writeData : regs[read1Sel];
   assign read2Data = hit2 ? writeData : regs[read2Sel];

endmodule

`default_nettype wire
